// File: common/wavegen_pkg.sv
// vector wavegen shared package with sizes, framing bytes, opcodes and list structs
`default_nettype none

package wavegen_pkg;

    ////////////////////////////////////////
    // sizes and timing
    ////////////////////////////////////////
    localparam int pos_w        = 8;    // dac position and parameter width
    localparam int list_depth   = 16;   // display-list entries per axis
    localparam int index_w      = 4;    // entry index width
    localparam int clks_per_bit = 16;   // uart bit period in clocks

    // packet framing
    localparam logic [7:0] hdr_byte = 8'hAA;
    localparam logic [7:0] trl_byte = 8'h55;

    ////////////////////////////////////////
    // enums
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        op_nop       = 3'd0,
        op_line      = 3'd1,
        op_incr      = 3'd2,
        op_decr      = 3'd3,
        op_jump      = 3'd4,
        op_x_rect    = 3'd5,
        op_y_rect    = 3'd6,
        op_line_down = 3'd7
    } opcode_t;

    typedef enum logic [1:0] {
        mv_up,
        mv_down,
        mv_hold
    } motion_t;

    // rect ops walk all four phases, line ops use start and one
    typedef enum logic [2:0] {
        ph_start,
        ph_one,
        ph_two,
        ph_three,
        ph_done
    } phase_t;

    typedef enum logic [1:0] {
        fld_op,
        fld_a,
        fld_b,
        fld_c
    } field_t;

    ////////////////////////////////////////
    // structs
    ////////////////////////////////////////
    typedef struct packed {
        opcode_t          op;
        logic [pos_w-1:0] a;
        logic [pos_w-1:0] b;
        logic [pos_w-1:0] c;
    } entry_t;

    typedef struct packed {
        logic               valid;
        logic               axis;   // 0 x, 1 y
        field_t             field;
        logic [index_w-1:0] index;
        logic [pos_w-1:0]   data;
    } list_wr_t;

endpackage

`default_nettype wire

// File: loader/program_loader.sv
// packet loader, frames received bytes and turns the payload into display-list writes
`timescale 1ns/1ps
`default_nettype none

module program_loader import wavegen_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic [pos_w-1:0] rx_byte,
    input  logic             rx_valid,
    output list_wr_t         list_wr,
    output logic             loaded
);

    // header, type, 16 data bytes, trailer
    typedef enum logic [1:0] {
        ld_idle,
        ld_type,
        ld_data,
        ld_trailer
    } ld_state_t;

    ld_state_t          state;
    logic [2:0]         sel;        // type byte, axis in bit 2, field in 1:0
    logic [index_w-1:0] count;      // data byte number
    list_wr_t           wr_q;

    ////////////////////////////////////////
    // framing fsm
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ld_idle;
            count      <= '0;
            loaded     <= 1'b0;
            wr_q.valid <= 1'b0;
        end else begin
            wr_q.valid <= 1'b0;     // one write per data byte
            if (rx_valid) begin
                case (state)
                    ld_idle: begin
                        if (rx_byte == hdr_byte)
                            state <= ld_type;
                    end
                    ld_type: begin
                        sel   <= rx_byte[2:0];
                        count <= '0;
                        state <= ld_data;
                    end
                    ld_data: begin
                        wr_q.valid <= 1'b1;
                        wr_q.axis  <= sel[2];
                        wr_q.field <= field_t'(sel[1:0]);
                        wr_q.index <= count;
                        wr_q.data  <= rx_byte;
                        count      <= count + 1'b1;
                        if (count == index_w'(list_depth - 1))
                            state <= ld_trailer;
                    end
                    ld_trailer: begin
                        // a bad trailer leaves loaded untouched
                        if (rx_byte == trl_byte)
                            loaded <= 1'b1;
                        state <= ld_idle;
                    end
                    default: state <= ld_idle;
                endcase
            end
        end
    end

    assign list_wr = wr_q;

endmodule

`default_nettype wire

// File: logic/axis_sequencer.sv
// axis sequencer, steps one dac position through the current display-list entry
`timescale 1ns/1ps
`default_nettype none

module axis_sequencer import wavegen_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             run,
    input  logic             advance,
    input  entry_t           entry,
    output logic [pos_w-1:0] pos,
    output logic             done
);

    phase_t           phase;
    logic [pos_w-1:0] cnt;          // steps taken in this phase
    logic [pos_w-1:0] cnt_inc;
    logic [pos_w-1:0] cnt_nxt;
    logic [pos_w-1:0] pos_nxt;
    phase_t           phase_nxt;
    phase_t           cur;          // rect phase actually stepped this cycle
    motion_t          mv;
    logic             load;         // jump or line start, pos takes a
    logic             last;         // this step ends the entry

    // rect phases run a, b, a, b steps long
    function automatic logic [pos_w-1:0] phase_len(input phase_t p,
                                                   input logic [pos_w-1:0] a,
                                                   input logic [pos_w-1:0] b);
        return (p == ph_start || p == ph_two) ? a : b;
    endfunction

    // first phase at or after p with a nonzero length
    function automatic phase_t skip_empty(input phase_t p,
                                          input logic [pos_w-1:0] a,
                                          input logic [pos_w-1:0] b);
        phase_t q;
        q = p;
        for (int i = 0; i < 4; i++) begin
            if (q != ph_done && phase_len(q, a, b) == '0)
                q = phase_t'(q + 3'd1);
        end
        return q;
    endfunction

    ////////////////////////////////////////
    // step decode
    ////////////////////////////////////////
    always_comb begin
        mv        = mv_hold;
        load      = 1'b0;
        last      = 1'b0;
        cur       = phase;
        phase_nxt = phase;
        cnt_inc   = cnt + 1'b1;
        cnt_nxt   = cnt_inc;
        case (entry.op)
            op_nop: last = 1'b1;
            op_jump: begin
                load = 1'b1;
                last = 1'b1;
            end
            op_line, op_line_down: begin
                if (phase == ph_start) begin
                    load      = 1'b1;
                    phase_nxt = ph_one;
                    cnt_nxt   = '0;
                    last      = (entry.b == '0);
                end else begin
                    mv   = (entry.op == op_line) ? mv_up : mv_down;
                    last = (cnt_inc == entry.b);
                end
            end
            op_incr, op_decr: begin
                if (entry.a != '0)
                    mv = (entry.op == op_incr) ? mv_up : mv_down;
                last = (entry.a == '0) || (cnt_inc == entry.a);  // zero gives a hold step
            end
            default: begin      // x_rect and y_rect
                cur = skip_empty(phase, entry.a, entry.b);
                if (cur == ph_done) begin
                    last = 1'b1;                // a and b both zero
                end else begin
                    if (entry.op == op_x_rect)
                        mv = (cur == ph_start) ? mv_up : (cur == ph_two) ? mv_down : mv_hold;
                    else
                        mv = (cur == ph_one) ? mv_up : (cur == ph_three) ? mv_down : mv_hold;
                    phase_nxt = cur;
                    if (cnt_inc == phase_len(cur, entry.a, entry.b)) begin
                        phase_nxt = phase_t'(cur + 3'd1);
                        cnt_nxt   = '0;
                        last      = (skip_empty(phase_nxt, entry.a, entry.b) == ph_done);
                    end
                end
            end
        endcase

        case (mv)
            mv_up:   pos_nxt = pos + entry.c;   // wraps mod 256
            mv_down: pos_nxt = pos - entry.c;
            default: pos_nxt = pos;
        endcase
        if (load)
            pos_nxt = entry.a;
    end

    ////////////////////////////////////////
    // state
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= ph_start;
            cnt   <= '0;
            pos   <= '0;
            done  <= 1'b0;
        end else if (run) begin
            if (advance) begin
                phase <= ph_start;
                cnt   <= '0;
                done  <= 1'b0;
            end else if (!done) begin
                pos   <= pos_nxt;
                cnt   <= cnt_nxt;
                phase <= last ? ph_done : phase_nxt;
                done  <= last;      // held until the next advance
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/display_list.sv
// display list, x and y entry tables with the shared pointer and lockstep advance
`timescale 1ns/1ps
`default_nettype none

module display_list import wavegen_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  list_wr_t           list_wr,
    input  logic               x_done,
    input  logic               y_done,
    input  logic               run,
    output entry_t             x_entry,
    output entry_t             y_entry,
    output logic               advance,
    output logic [index_w-1:0] list_index
);

    entry_t x_tab [list_depth];
    entry_t y_tab [list_depth];

    // merge one byte into an entry
    function automatic entry_t put_field(input entry_t old, input list_wr_t w);
        entry_t e;
        e = old;
        case (w.field)
            fld_op: e.op = opcode_t'(w.data[2:0]);  // upper bits ignored
            fld_a:  e.a  = w.data;
            fld_b:  e.b  = w.data;
            fld_c:  e.c  = w.data;
            default: e = old;
        endcase
        return e;
    endfunction

    ////////////////////////////////////////
    // table storage
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < list_depth; i++) begin
                x_tab[i] <= '{op: op_nop, a: '0, b: '0, c: '0};
                y_tab[i] <= '{op: op_nop, a: '0, b: '0, c: '0};
            end
        end else if (list_wr.valid) begin
            if (list_wr.axis)
                y_tab[list_wr.index] <= put_field(y_tab[list_wr.index], list_wr);
            else
                x_tab[list_wr.index] <= put_field(x_tab[list_wr.index], list_wr);
        end
    end

    assign x_entry = x_tab[list_index];
    assign y_entry = y_tab[list_index];

    ////////////////////////////////////////
    // pointer and advance
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            list_index <= '0;
            advance    <= 1'b0;
        end else begin
            // fires the cycle after both axes report done, one cycle wide
            advance <= run && x_done && y_done && !advance;
            if (run && advance)
                list_index <= list_index + 1'b1;    // 15 wraps to 0
        end
    end

endmodule

`default_nettype wire

// File: logic/vector_wavegen.sv
// vector wavegen top, uart-loaded display list driving the x and y dac sequencers
`timescale 1ns/1ps
`default_nettype none

module vector_wavegen import wavegen_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    input  logic               rxd,
    output logic [pos_w-1:0]   xdac,
    output logic [pos_w-1:0]   ydac,
    output logic [index_w-1:0] list_index,
    output logic               loaded
);

    logic [pos_w-1:0] rx_byte;
    logic             rx_valid;
    list_wr_t         list_wr;
    entry_t           x_entry;
    entry_t           y_entry;
    logic             advance;
    logic             x_done;
    logic             y_done;

    ////////////////////////////////////////
    // loading path
    ////////////////////////////////////////
    uart_rx rx0 (
        .clk      (clk),
        .reset    (reset),
        .rxd      (rxd),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    program_loader loader0 (
        .clk      (clk),
        .reset    (reset),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .list_wr  (list_wr),
        .loaded   (loaded)
    );

    display_list list0 (
        .clk        (clk),
        .reset      (reset),
        .list_wr    (list_wr),
        .x_done     (x_done),
        .y_done     (y_done),
        .run        (enable || loaded),
        .x_entry    (x_entry),
        .y_entry    (y_entry),
        .advance    (advance),
        .list_index (list_index)
    );

    ////////////////////////////////////////
    // drawing path, both axes in lockstep
    ////////////////////////////////////////
    axis_sequencer x_axis (
        .clk     (clk),
        .reset   (reset),
        .run     (enable || loaded),
        .advance (advance),
        .entry   (x_entry),
        .pos     (xdac),
        .done    (x_done)
    );

    axis_sequencer y_axis (
        .clk     (clk),
        .reset   (reset),
        .run     (enable || loaded),
        .advance (advance),
        .entry   (y_entry),
        .pos     (ydac),
        .done    (y_done)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    -f vector_wavegen.f --top-module vector_wavegen_tb -o vsim
out="$(./obj_dir/vsim)"
echo "$out"
if echo "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1

// File: sim/vector_wavegen_asserts.sv
// vector wavegen assertions, loaded flag, pointer stepping and dac hold while stopped
`timescale 1ns/1ps
`default_nettype none

module vector_wavegen_asserts import wavegen_pkg::*; (
    input logic               clk,
    input logic               reset,
    input logic               enable,
    input logic               loaded,
    input logic [pos_w-1:0]   xdac,
    input logic [pos_w-1:0]   ydac,
    input logic [index_w-1:0] list_index
);

    // loaded only clears through reset
    property loaded_sticks;
        @(posedge clk) disable iff (reset)
            (!$past(reset) && $past(loaded)) |-> loaded;
    endproperty

    // pointer moves by one, 15 wraps to 0
    property index_steps_by_one;
        @(posedge clk) disable iff (reset)
            (!$past(reset) && list_index != $past(list_index))
                |-> list_index == index_w'($past(list_index) + 1'b1);
    endproperty

    property dacs_hold_when_stopped;
        @(posedge clk) disable iff (reset)
            (!$past(reset) && !$past(enable || loaded))
                |-> (xdac == $past(xdac) && ydac == $past(ydac));
    endproperty

    loaded_a: assert property (loaded_sticks)
        else $error("loaded fell without reset");
    index_a: assert property (index_steps_by_one)
        else $error("list_index jumped by more than one");
    hold_a: assert property (dacs_hold_when_stopped)
        else $error("dac moved while run was low");

endmodule

bind vector_wavegen vector_wavegen_asserts asserts0 (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .loaded     (loaded),
    .xdac       (xdac),
    .ydac       (ydac),
    .list_index (list_index)
);

`default_nettype wire

// File: sim/vector_wavegen_tb.sv
// vector wavegen testbench that loads tables over uart and checks dac end positions per entry
`timescale 1ns/1ps
`default_nettype none

module vector_wavegen_tb import wavegen_pkg::*; ();

    localparam int packet_cycles = 19 * 10 * clks_per_bit;
    localparam int watchdog_cycles = 44 * packet_cycles + 20000;

    logic               clk = 1'b0;
    logic               reset = 1'b1;
    logic               enable = 1'b0;
    logic               rxd = 1'b1;
    logic [pos_w-1:0]   xdac;
    logic [pos_w-1:0]   ydac;
    logic [index_w-1:0] list_index;
    logic               loaded;

    entry_t             x_prog [list_depth];
    entry_t             y_prog [list_depth];
    logic [31:0]        lfsr_state = 32'he477_a209;
    int                 errors = 0;
    int                 tests_failed = 0;
    int                 tests_run = 0;

    // records the dac positions seen at each pointer change
    int                 n_adv;
    logic [index_w-1:0] prev_idx;
    logic [pos_w-1:0]   cur_peak;
    logic [pos_w-1:0]   rec_x [64];
    logic [pos_w-1:0]   rec_y [64];
    logic [pos_w-1:0]   peak_x [64];

    vector_wavegen dut0 (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .rxd        (rxd),
        .xdac       (xdac),
        .ydac       (ydac),
        .list_index (list_index),
        .loaded     (loaded)
    );

    always #5 clk = ~clk;

    always @(negedge clk) begin
        if (reset) begin
            n_adv    = 0;
            prev_idx = '0;
            cur_peak = '0;
        end else begin
            if (xdac > cur_peak)
                cur_peak = xdac;
            if (list_index != prev_idx) begin
                if (n_adv < 64) begin
                    rec_x[n_adv]  = xdac;
                    rec_y[n_adv]  = ydac;
                    peak_x[n_adv] = cur_peak;
                end
                n_adv    = n_adv + 1;
                prev_idx = list_index;
                cur_peak = xdac;    // start of the next entry
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    // final position of one entry from its start position
    function automatic logic [pos_w-1:0] end_pos(input entry_t e, input logic [pos_w-1:0] s);
        logic [pos_w-1:0] r;
        case (e.op)
            op_jump:      r = e.a;
            op_line:      r = e.a + e.b * e.c;
            op_line_down: r = e.a - e.b * e.c;
            op_incr:      r = s + e.a * e.c;
            op_decr:      r = s - e.a * e.c;
            default:      r = s;        // nop and both rects end where they began
        endcase
        return r;
    endfunction

    task automatic mismatch(input string what, input int expv, input int got);
        $display("Mismatch at %0t: %s expected %0d got %0d", $time, what, expv, got);
        errors++;
    endtask

    task automatic do_reset();
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic clear_prog();
        for (int i = 0; i < list_depth; i++) begin
            x_prog[i] = '{op: op_nop, a: '0, b: '0, c: '0};
            y_prog[i] = '{op: op_nop, a: '0, b: '0, c: '0};
        end
    endtask

    task automatic random_prog();
        int r;
        for (int i = 0; i < list_depth; i++) begin
            r = rand_bits(3);
            x_prog[i].op = (r == 5 || r == 6) ? op_jump : opcode_t'(r);
            x_prog[i].a  = 8'(rand_bits(3));
            x_prog[i].b  = 8'(rand_bits(3));
            x_prog[i].c  = 8'(rand_bits(3));
            r = rand_bits(3);
            y_prog[i].op = (r == 5 || r == 6) ? op_jump : opcode_t'(r);
            y_prog[i].a  = 8'(rand_bits(3));
            y_prog[i].b  = 8'(rand_bits(3));
            y_prog[i].c  = 8'(rand_bits(3));
        end
    endtask

    // start bit, 8 data bits lsb first, stop bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rxd = frame[i];
            repeat (clks_per_bit) @(negedge clk);
        end
    endtask

    task automatic send_packet(input int sel, input logic [7:0] hdr, input logic [7:0] trl);
        entry_t e;
        send_byte(hdr);
        send_byte(8'(sel));
        for (int i = 0; i < list_depth; i++) begin
            e = (sel >= 4) ? y_prog[i] : x_prog[i];
            case (sel % 4)
                0: send_byte({5'b0, e.op});
                1: send_byte(e.a);
                2: send_byte(e.b);
                default: send_byte(e.c);
            endcase
        end
        send_byte(trl);
    endtask

    // the first seven tables close with a bad trailer, so loaded rises with the last one
    task automatic load_table();
        for (int s = 0; s < 8; s++)
            send_packet(s, hdr_byte, (s == 7) ? trl_byte : 8'h5A);
    endtask

    task automatic wait_advances(input int n);
        int cycles;
        cycles = 0;
        while (n_adv < n && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);
        if (n_adv < n) begin
            $display("timed out waiting for %0d advances, saw %0d", n, n_adv);
            errors++;
        end
    endtask

    // compares recorded end positions with the chained model from zero
    task automatic check_laps(input int count);
        logic [pos_w-1:0] px;
        logic [pos_w-1:0] py;
        px = '0;
        py = '0;
        for (int i = 0; i < count; i++) begin
            px = end_pos(x_prog[i % list_depth], px);
            py = end_pos(y_prog[i % list_depth], py);
            if (rec_x[i] !== px)
                mismatch($sformatf("xdac end of step %0d", i), px, rec_x[i]);
            if (rec_y[i] !== py)
                mismatch($sformatf("ydac end of step %0d", i), py, rec_y[i]);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("%s: failed", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////
    task automatic test_reset();
        int e0;
        e0 = errors;
        do_reset();
        for (int i = 0; i < 100; i++) begin
            @(negedge clk);
            if (xdac !== 0 || ydac !== 0 || list_index !== 0 || loaded !== 0) begin
                $display("outputs left their reset values with enable low");
                errors++;
                break;
            end
        end
        finish_test("reset", e0);
    endtask

    task automatic test_framing();
        int e0;
        int cycles;
        e0 = errors;
        do_reset();
        clear_prog();
        send_packet(0, 8'hAB, trl_byte);    // wrong header
        repeat (20) @(negedge clk);
        if (loaded !== 1'b0)
            mismatch("loaded after bad header", 0, loaded);
        send_packet(0, hdr_byte, 8'h12);    // wrong trailer
        repeat (20) @(negedge clk);
        if (loaded !== 1'b0)
            mismatch("loaded after bad trailer", 0, loaded);
        for (int s = 0; s < 8; s++)
            send_packet(s, hdr_byte, trl_byte);
        cycles = 0;
        while (loaded !== 1'b1 && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (loaded !== 1'b1)
            mismatch("loaded after good packets", 1, loaded);
        finish_test("framing", e0);
    endtask

    task automatic test_lines();
        int e0;
        e0 = errors;
        do_reset();
        random_prog();
        load_table();
        wait_advances(list_depth);
        check_laps(list_depth);
        finish_test("lines and jumps", e0);
    endtask

    task automatic test_rect();
        int e0;
        e0 = errors;
        do_reset();
        clear_prog();
        x_prog[0] = '{op: op_jump, a: 8'd10, b: '0, c: '0};
        y_prog[0] = '{op: op_jump, a: 8'd20, b: '0, c: '0};
        x_prog[1] = '{op: op_x_rect, a: 8'd3, b: 8'd2, c: 8'd5};
        y_prog[1] = '{op: op_y_rect, a: 8'd2, b: 8'd4, c: 8'd3};
        load_table();
        wait_advances(list_depth);
        check_laps(list_depth);
        if (peak_x[1] !== 8'd25)
            mismatch("x_rect peak", 25, peak_x[1]);
        finish_test("rectangles", e0);
    endtask

    task automatic test_lockstep();
        int e0;
        int cycles;
        logic seen;
        e0 = errors;
        do_reset();
        clear_prog();
        x_prog[0] = '{op: op_jump, a: 8'd77, b: '0, c: '0};
        y_prog[0] = '{op: op_incr, a: 8'd40, b: '0, c: 8'd1};
        load_table();
        seen = 1'b0;
        cycles = 0;
        while (list_index == 0 && cycles < 2000) begin
            @(negedge clk);
            cycles++;
            if (xdac == 8'd77)
                seen = 1'b1;
            else if (seen && list_index == 0)
                mismatch("xdac while waiting for y", 77, xdac);
        end
        if (list_index == 0) begin
            $display("list_index never left entry 0");
            errors++;
        end else begin
            if (ydac !== 8'd40)
                mismatch("ydac at advance", 40, ydac);
            if (xdac !== 8'd77)
                mismatch("xdac at advance", 77, xdac);
        end
        finish_test("lockstep", e0);
    endtask

    task automatic test_enable_wrap();
        int e0;
        logic [index_w-1:0] held;
        e0 = errors;
        do_reset();
        enable = 1'b1;              // empty list of nops advances on enable alone
        repeat (40) @(negedge clk);
        enable = 1'b0;
        if (list_index == 0) begin
            $display("list_index did not move with enable high");
            errors++;
        end
        held = list_index;
        repeat (40) @(negedge clk);
        if (list_index !== held)
            mismatch("list_index with enable low", held, list_index);
        do_reset();
        random_prog();
        x_prog[0].op = op_jump;     // both laps start from the same place
        y_prog[0].op = op_jump;
        for (int s = 0; s < 7; s++)
            send_packet(s, hdr_byte, 8'h5A);
        if (xdac !== 0 || ydac !== 0 || list_index !== 0 || loaded !== 0) begin
            $display("drawing started before the last packet");
            errors++;
        end
        send_packet(7, hdr_byte, trl_byte);
        wait_advances(2 * list_depth);
        check_laps(2 * list_depth);
        if (list_index !== 0)
            mismatch("list_index after two laps", 0, list_index);
        finish_test("enable and wrap", e0);
    endtask

    initial begin
        test_reset();
        test_framing();
        test_lines();
        test_rect();
        test_lockstep();
        test_enable_wrap();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: uart/uart_rx.sv
// uart receiver, samples each bit mid-period and drops bytes with a bad stop bit
`timescale 1ns/1ps
`default_nettype none

module uart_rx import wavegen_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             rxd,
    output logic [pos_w-1:0] rx_byte,
    output logic             rx_valid
);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t                       state;
    logic [1:0]                      sync;      // two-flop synchronizer
    logic [$clog2(clks_per_bit)-1:0] tick;      // clocks into the current bit
    logic [2:0]                      bit_cnt;
    logic [pos_w-1:0]                shift;
    logic                            rx_bit;
    logic                            half_end;
    logic                            full_end;

    assign rx_bit   = sync[1];
    assign half_end = (int'(tick) == clks_per_bit / 2 - 1);
    assign full_end = (int'(tick) == clks_per_bit - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            sync     <= 2'b11;      // line idles high
            state    <= rx_idle;
            tick     <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync     <= {sync[0], rxd};
            rx_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    tick <= '0;
                    if (!rx_bit)
                        state <= rx_start;
                end
                rx_start: begin
                    tick <= tick + 1'b1;
                    if (half_end) begin         // middle of start bit
                        tick    <= '0;
                        bit_cnt <= '0;
                        state   <= rx_bit ? rx_idle : rx_data;  // false start
                    end
                end
                rx_data: begin
                    tick <= tick + 1'b1;
                    if (full_end) begin
                        tick    <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= rx_stop;
                    end
                end
                rx_stop: begin
                    tick <= tick + 1'b1;
                    if (full_end) begin
                        rx_valid <= rx_bit;     // only a good stop bit delivers
                        state    <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state == rx_data && full_end)
            shift <= {rx_bit, shift[pos_w-1:1]};
    end

    assign rx_byte = shift;

endmodule

`default_nettype wire

// File: vector_wavegen.f
common/wavegen_pkg.sv
uart/uart_rx.sv
loader/program_loader.sv
logic/display_list.sv
logic/axis_sequencer.sv
logic/vector_wavegen.sv
sim/vector_wavegen_asserts.sv
sim/vector_wavegen_tb.sv
